/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;
    localparam logic [REG_ADDR_W-1:0] V0_REG = 5'd2;
    localparam logic [REG_ADDR_W-1:0] A0_REG = 5'd4;

    // $v0 value that stops the core on syscall
    localparam logic [XLEN-1:0] HALT_CODE = 32'd10;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // all zero is a bubble
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    use_shamt;
        logic    sign_ext;
        logic    reg_write;
        logic    dst_rd;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    link;
        logic    jump_reg;
        logic    syscall;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [15:0]           imm16;
        logic [XLEN-1:0]       rs_val;
        logic [XLEN-1:0]       rt_val;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  syscall;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  syscall;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* src/mips_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_decoder (
    input  logic [mips_pkg::XLEN-1:0]       instr,
    output mips_pkg::ctrl_t                 ctrl,
    output logic [mips_pkg::REG_ADDR_W-1:0] rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] rd,
    output logic [4:0]                      shamt,
    output logic [15:0]                     imm16,
    output logic [25:0]                     imm26
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm16  = instr[15:0];
    assign imm26  = instr[25:0];

    // sll shifts rt, so present it as the first source too
    assign rs = ctrl.use_shamt ? instr[20:16] : instr[25:21];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst_rd    = 1'b1;
                case (funct)
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_OR:  ctrl.alu_op = ALU_OR;
                    FN_SLT: ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.use_shamt = 1'b1;
                    end
                    FN_JR: begin
                        ctrl          = '0;
                        ctrl.jump_reg = 1'b1;
                    end
                    FN_SYSCALL: begin
                        ctrl         = '0;
                        ctrl.syscall = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.sign_ext    = 1'b1;
            end
            OP_ANDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_AND;
            end
            OP_ORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_OR;
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.sign_ext    = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.sign_ext    = 1'b1;
            end
            OP_BEQ: ctrl.branch_eq = 1'b1;
            OP_BNE: ctrl.branch_ne = 1'b1;
            OP_J:   ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // anything else runs as a nop
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload is a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [mips_pkg::XLEN-1:0]       wdata,
    output logic [mips_pkg::XLEN-1:0]       rdata_a,
    output logic [mips_pkg::XLEN-1:0]       rdata_b,
    output logic [mips_pkg::XLEN-1:0]       v0_data,
    output logic [mips_pkg::XLEN-1:0]       a0_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // $zero reads as zero, a same-cycle write is passed through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (we && addr == waddr)
            return wdata;
        return regs[addr];
    endfunction

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
        v0_data = read_port(V0_REG);
        a0_data = read_port(A0_REG);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [mips_pkg::XLEN-1:0] a,
    input  logic [mips_pkg::XLEN-1:0] b,
    input  mips_pkg::alu_op_t         op,
    output logic [mips_pkg::XLEN-1:0] result
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            // shift amount arrives on a
            ALU_SLL: result = b << a[4:0];
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem (
    input  logic                         clk,
    input  logic                         we,
    input  logic [mips_pkg::DMEM_AW-1:0] addr,
    input  logic [mips_pkg::XLEN-1:0]    wdata,
    output logic [mips_pkg::XLEN-1:0]    rdata
);
    import mips_pkg::*;

    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic [mips_pkg::REG_ADDR_W-1:0] id_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] id_rt,
    input  mips_pkg::ctrl_t                 id_ctrl,
    input  logic                            redirect,
    input  logic                            halted,
    input  mips_pkg::id_ex_t                id_ex,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_dest,
    input  mips_pkg::ex_mem_t               ex_mem,
    input  mips_pkg::mem_wb_t               mem_wb,
    output mips_pkg::fwd_sel_t              id_fwd_a,
    output mips_pkg::fwd_sel_t              id_fwd_b,
    output mips_pkg::fwd_sel_t              ex_fwd_a,
    output mips_pkg::fwd_sel_t              ex_fwd_b,
    output mips_pkg::fwd_sel_t              mem_fwd_store,
    output logic                            stall_id,
    output logic                            flush_if,
    output logic                            freeze
);
    import mips_pkg::*;

    logic reads_rs;
    logic reads_rt;
    logic needs_operands;
    logic ex_hit;
    logic mem_load_hit;
    logic load_use;
    logic branch_wait;

    // youngest producer wins
    function automatic fwd_sel_t pick(input logic [REG_ADDR_W-1:0] src);
        if (ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == src)
            return FWD_MEM;
        if (mem_wb.reg_write && mem_wb.dest != '0 && mem_wb.dest == src)
            return FWD_WB;
        return FWD_RF;
    endfunction

    always_comb begin
        id_fwd_a = pick(id_rs);
        id_fwd_b = pick(id_rt);
        ex_fwd_a = pick(id_ex.rs);
        ex_fwd_b = pick(id_ex.rt);
        mem_fwd_store = FWD_RF;
        if (ex_mem.mem_write && mem_wb.reg_write && mem_wb.dest != '0
                && mem_wb.dest == ex_mem.rt)
            mem_fwd_store = FWD_WB;
    end

    // store data in rt is fixed up in MEM, so it never stalls
    assign reads_rs = (id_ctrl.reg_write && !id_ctrl.link) || id_ctrl.mem_write
                   || id_ctrl.branch_eq || id_ctrl.branch_ne || id_ctrl.jump_reg;
    assign reads_rt = reads_rs && !id_ctrl.alu_src_imm && !id_ctrl.jump_reg;
    assign needs_operands = id_ctrl.branch_eq || id_ctrl.branch_ne || id_ctrl.jump_reg;

    assign ex_hit = ex_dest != '0
                 && ((reads_rs && ex_dest == id_rs) || (reads_rt && ex_dest == id_rt));
    assign mem_load_hit = ex_mem.mem_read && ex_mem.dest != '0
                       && ((reads_rs && ex_mem.dest == id_rs)
                           || (reads_rt && ex_mem.dest == id_rt));

    assign load_use    = id_ex.ctrl.mem_read && ex_hit;
    assign branch_wait = needs_operands
                      && ((id_ex.ctrl.reg_write && ex_hit) || mem_load_hit);

    assign freeze   = halted;
    assign stall_id = (load_use || branch_wait) && !halted;
    assign flush_if = redirect && !stall_id && !halted;

endmodule

`default_nettype wire

/* src/mips_core.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mips_pkg::XLEN-1:0] instr,
    output logic [mips_pkg::XLEN-1:0] imem_addr,
    output logic                      print_valid,
    output logic [mips_pkg::XLEN-1:0] print_data,
    output logic                      halted
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    if_id_t          if_id_d;
    if_id_t          if_id_q;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    mem_wb_t         mem_wb_d;
    mem_wb_t         mem_wb_q;

    ctrl_t                 id_ctrl;
    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [4:0]            id_shamt;
    logic [15:0]           id_imm16;
    logic [25:0]           id_imm26;
    logic [XLEN-1:0]       rf_a;
    logic [XLEN-1:0]       rf_b;
    logic [XLEN-1:0]       id_a;
    logic [XLEN-1:0]       id_b;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       branch_target;
    logic [XLEN-1:0]       jump_target;
    logic                  taken;
    logic                  redirect;

    logic [REG_ADDR_W-1:0] ex_dest;
    logic [XLEN-1:0]       ex_a;
    logic [XLEN-1:0]       ex_b;
    logic [XLEN-1:0]       imm32;
    logic [XLEN-1:0]       alu_a;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;

    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] v0_data;
    logic [XLEN-1:0] a0_data;
    logic            halt_req;

    fwd_sel_t id_fwd_a;
    fwd_sel_t id_fwd_b;
    fwd_sel_t ex_fwd_a;
    fwd_sel_t ex_fwd_b;
    fwd_sel_t mem_fwd_store;
    logic     stall_id;
    logic     flush_if;
    logic     freeze;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] reg_val
    );
        case (sel)
            FWD_MEM: return ex_mem_q.alu_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!(stall_id || freeze)) begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr = pc_q;
    assign if_id_d   = '{pc: pc_q, instr: instr};

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (stall_id || freeze),
        .flush (flush_if),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // decode and branch resolve
    mips_decoder u_decoder (
        .instr (if_id_q.instr),
        .ctrl  (id_ctrl),
        .rs    (id_rs),
        .rt    (id_rt),
        .rd    (id_rd),
        .shamt (id_shamt),
        .imm16 (id_imm16),
        .imm26 (id_imm26)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (mem_wb_q.reg_write && !freeze),
        .raddr_a (id_rs),
        .raddr_b (id_rt),
        .waddr   (mem_wb_q.dest),
        .wdata   (wb_data),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .v0_data (v0_data),
        .a0_data (a0_data)
    );

    always_comb begin
        id_a = fwd_mux(id_fwd_a, rf_a);
        id_b = fwd_mux(id_fwd_b, rf_b);
        ex_a = fwd_mux(ex_fwd_a, id_ex_q.rs_val);
        ex_b = fwd_mux(ex_fwd_b, id_ex_q.rt_val);
    end

    assign pc_plus4      = if_id_q.pc + 32'd4;
    assign branch_target = pc_plus4 + {{(XLEN-18){id_imm16[15]}}, id_imm16, 2'b00};
    assign jump_target   = {pc_plus4[XLEN-1:28], id_imm26, 2'b00};
    assign taken    = (id_ctrl.branch_eq && id_a == id_b)
                   || (id_ctrl.branch_ne && id_a != id_b);
    assign redirect = taken || id_ctrl.jump || id_ctrl.jump_reg;
    assign pc_next  = id_ctrl.jump_reg ? id_a
                    : id_ctrl.jump     ? jump_target
                    : taken            ? branch_target
                    : pc_q + 32'd4;

    assign id_ex_d = '{
        pc:     if_id_q.pc,
        ctrl:   id_ctrl,
        rs:     id_rs,
        rt:     id_rt,
        rd:     id_rd,
        shamt:  id_shamt,
        imm16:  id_imm16,
        rs_val: rf_a,
        rt_val: rf_b
    };

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (freeze),
        .flush (stall_id),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    // execute; jal computes pc+4 into $ra
    assign ex_dest = id_ex_q.ctrl.link   ? RA_REG
                   : id_ex_q.ctrl.dst_rd ? id_ex_q.rd
                   : id_ex_q.rt;
    assign imm32 = id_ex_q.ctrl.sign_ext ? {{(XLEN-16){id_ex_q.imm16[15]}}, id_ex_q.imm16}
                                         : {{(XLEN-16){1'b0}}, id_ex_q.imm16};
    assign alu_a = id_ex_q.ctrl.use_shamt ? {{(XLEN-5){1'b0}}, id_ex_q.shamt}
                 : id_ex_q.ctrl.link      ? id_ex_q.pc
                 : ex_a;
    assign alu_b = id_ex_q.ctrl.link        ? 32'd4
                 : id_ex_q.ctrl.alu_src_imm ? imm32
                 : ex_b;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex_q.ctrl.alu_op),
        .result (alu_result)
    );

    assign ex_mem_d = '{
        reg_write:  id_ex_q.ctrl.reg_write,
        mem_read:   id_ex_q.ctrl.mem_read,
        mem_write:  id_ex_q.ctrl.mem_write,
        syscall:    id_ex_q.ctrl.syscall,
        rt:         id_ex_q.rt,
        dest:       ex_dest,
        alu_result: alu_result,
        store_data: ex_b
    };

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (freeze),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // memory
    assign store_data = (mem_fwd_store == FWD_WB) ? wb_data : ex_mem_q.store_data;

    data_mem u_data_mem (
        .clk   (clk),
        .we    (ex_mem_q.mem_write && !freeze),
        .addr  (ex_mem_q.alu_result[2 +: DMEM_AW]),
        .wdata (store_data),
        .rdata (load_data)
    );

    assign mem_wb_d = '{
        reg_write:  ex_mem_q.reg_write,
        mem_read:   ex_mem_q.mem_read,
        syscall:    ex_mem_q.syscall,
        dest:       ex_mem_q.dest,
        alu_result: ex_mem_q.alu_result,
        load_data:  load_data
    };

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (freeze),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // write-back and syscall
    assign wb_data  = mem_wb_q.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign halt_req = mem_wb_q.syscall && v0_data == HALT_CODE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

    assign print_valid = mem_wb_q.syscall && !halt_req && !halted;
    assign print_data  = a0_data;

    // the halting syscall freezes the pipe in the same cycle
    hazard_unit u_hazard (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_ctrl       (id_ctrl),
        .redirect      (redirect),
        .halted        (halted || halt_req),
        .id_ex         (id_ex_q),
        .ex_dest       (ex_dest),
        .ex_mem        (ex_mem_q),
        .mem_wb        (mem_wb_q),
        .id_fwd_a      (id_fwd_a),
        .id_fwd_b      (id_fwd_b),
        .ex_fwd_a      (ex_fwd_a),
        .ex_fwd_b      (ex_fwd_b),
        .mem_fwd_store (mem_fwd_store),
        .stall_id      (stall_id),
        .flush_if      (flush_if),
        .freeze        (freeze)
    );

endmodule

`default_nettype wire

/* testbench/clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // release on a falling edge after 16 cycles
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/mips_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module mips_chk (
    input logic                      clk,
    input logic                      rst_n,
    input logic [mips_pkg::XLEN-1:0] imem_addr,
    input logic                      print_valid,
    input logic                      halted
);

    int fail_count = 0;

    // quiet during reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (imem_addr == '0 && !print_valid && !halted))
        else begin
            fail_count++;
            $error("core not idle during or right after reset");
        end

    print_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        print_valid |=> !print_valid)
        else begin
            fail_count++;
            $error("print_valid held high for more than one cycle");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without a reset");
        end

    halt_no_print: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !print_valid)
        else begin
            fail_count++;
            $error("print_valid pulsed while halted");
        end

    halt_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("imem_addr moved while halted");
        end

endmodule

bind mips_core mips_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr   (imem_addr),
    .print_valid (print_valid),
    .halted      (halted)
);

`default_nettype wire

/* testbench/tb_mips.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mips;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] imem_addr;
    logic        print_valid;
    logic [31:0] print_data;
    logic        halted;

    logic [31:0] rom [128];
    logic [31:0] expected [$];
    int          cur;
    int          cycles;
    int          chk_errors;
    int          print_errors = 0;
    int          other_errors = 0;
    int          prints_checked = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mips_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .imem_addr   (imem_addr),
        .print_valid (print_valid),
        .print_data  (print_data),
        .halted      (halted)
    );

    // combinational fetch, zero outside the rom
    assign instr = (imem_addr[31:9] == '0) ? rom[imem_addr[8:2]] : 32'd0;

    function automatic logic [31:0] r_word(input int fn, input int rs, input int rt,
                                           input int rd, input int sh);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] i_word(input int op, input int rs, input int rt,
                                           input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] j_word(input int op, input int target);
        return {6'(op), 26'(target)};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[cur] = w;
        cur++;
    endtask

    // add $a0, src, $zero then syscall
    task automatic emit_print(input int src, input logic [31:0] value);
        emit(r_word(32, src, 0, 4, 0));
        emit(r_word(12, 0, 0, 0, 0));
        expected.push_back(value);
    endtask

    task automatic emit_print_imm(input int value);
        emit(i_word(8, 0, 4, value));
        emit(r_word(12, 0, 0, 0, 0));
        expected.push_back(32'(value));
    endtask

    // on a path that must be skipped
    task automatic emit_dead_print();
        emit(i_word(8, 0, 4, 'h0bad));
        emit(r_word(12, 0, 0, 0, 0));
    endtask

    // unused words: nop or an opcode the core does not implement
    task automatic fill_rom();
        logic [5:0]  odd_ops [16];
        logic [31:0] r;
        odd_ops = '{6'h01, 6'h06, 6'h07, 6'h09, 6'h0a, 6'h0b, 6'h0e, 6'h0f,
                    6'h10, 6'h11, 6'h20, 6'h21, 6'h24, 6'h25, 6'h28, 6'h29};
        for (int i = 0; i < 128; i++) begin
            r = $urandom;
            if (r[0])
                rom[i] = 32'd0;
            else
                rom[i] = {odd_ops[r[4:1]], r[31:6]};
        end
    endtask

    task automatic load_program();
        int          ia;
        int          ib;
        int          n;
        int          loop_top;
        int          sub_at;
        int          ret_at;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t2;
        logic [31:0] t3;
        logic [31:0] t4;
        logic [31:0] t5;
        logic [31:0] sum;
        ia = 291;
        ib = -77;
        n = 5;
        sub_at = 96;
        a = ia;
        b = ib;
        t2 = a + b;
        t3 = t2 - a;
        t4 = t3 & t2;
        t5 = t4 | a;
        sum = 32'd1200 - 32'd45;

        cur = 0;
        emit(i_word(8, 0, 2, 1));
        cur++;
        emit(i_word(8, 0, 8, ia));
        emit(i_word(8, 0, 9, ib));
        emit(r_word(32, 8, 9, 10, 0));
        emit(r_word(34, 10, 8, 11, 0));
        emit(r_word(36, 11, 10, 12, 0));
        emit(r_word(37, 12, 8, 13, 0));
        emit(r_word(42, 9, 13, 14, 0));
        emit(r_word(0, 0, 13, 15, 4));
        emit_print(15, t5 << 4);
        emit(i_word(13, 12, 20, 'h8001));
        emit(i_word(12, 11, 21, 'hf0f0));
        emit_print(14, ($signed(b) < $signed(t5)) ? 32'd1 : 32'd0);
        emit_print(13, t5);
        emit_print(12, t4);
        emit_print(11, t3);
        emit_print(10, t2);
        emit_print(20, t4 | 32'h0000_8001);
        emit_print(21, t3 & 32'h0000_f0f0);

        // store then load back, load-use stall
        emit(i_word(8, 0, 16, 1200));
        emit(i_word(8, 0, 17, -45));
        emit(r_word(32, 16, 17, 8, 0));
        emit(i_word(43, 0, 8, 8));
        emit(i_word(35, 0, 9, 8));
        emit_print(9, sum);
        cur++;
        emit(i_word(35, 0, 9, 8));
        emit(i_word(43, 0, 9, 12));
        emit(i_word(35, 0, 11, 12));
        emit(r_word(32, 11, 9, 4, 0));
        emit(r_word(12, 0, 0, 0, 0));
        expected.push_back(sum + sum);

        // counted loop closed by bne on a fresh load
        emit(i_word(8, 0, 18, n));
        emit(i_word(43, 0, 18, 16));
        emit(i_word(8, 0, 19, 0));
        loop_top = cur;
        emit(i_word(8, 19, 19, 1));
        emit(i_word(35, 0, 12, 16));
        emit(i_word(5, 19, 12, loop_top - (cur + 1)));
        emit_print(19, n);
        emit(i_word(8, 19, 13, 0));
        emit(i_word(4, 13, 18, 2));
        emit_dead_print();
        emit_print_imm('h11);
        emit(i_word(4, 13, 0, 2));
        emit_print_imm('h22);
        emit(j_word(2, cur + 3));
        emit_dead_print();
        emit_print_imm('h55);

        emit(j_word(3, sub_at));
        // subroutine sits out of line, its print comes before the one after the call
        ret_at = cur;
        cur = sub_at;
        emit_print_imm('h33);
        emit(r_word(8, 31, 0, 0, 0));
        cur = ret_at;
        emit_print_imm('h44);
        emit(i_word(8, 0, 2, 10));
        emit(r_word(12, 0, 0, 0, 0));
    endtask

    task automatic check_print();
        logic [31:0] want;
        if (print_valid) begin
            if (expected.size() == 0) begin
                other_errors++;
                $display("unexpected print of %h at %0t", print_data, $time);
            end else begin
                want = expected.pop_front();
                prints_checked++;
                if (print_data !== want) begin
                    print_errors++;
                    $display("[FAIL] %0t print_data expected %h actual %h",
                             $time, want, print_data);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3b36));
        fill_rom();
        load_program();
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            other_errors++;
            $display("reset still asserted after %0d cycles", cycles);
        end else begin
            cycles = 0;
            while (!halted && cycles < 3000) begin
                @(negedge clk);
                check_print();
                cycles++;
            end
            if (!halted) begin
                other_errors++;
                $display("timeout, core did not halt within %0d cycles", cycles);
            end else begin
                if (expected.size() != 0) begin
                    other_errors++;
                    $display("core halted with %0d prints missing", expected.size());
                end
                // any print from here on is an error
                for (int i = 0; i < 20; i++) begin
                    @(negedge clk);
                    check_print();
                end
            end
        end
        chk_errors = DUT.u_chk.fail_count;
        $display("prints checked %0d, mismatches %0d, assertion failures %0d, other errors %0d",
                 prints_checked, print_errors, chk_errors, other_errors);
        if (print_errors + chk_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/mips_pkg.sv
src/mips_decoder.sv
src/pipe_reg.sv
src/regfile.sv
src/alu.sv
src/data_mem.sv
src/hazard_unit.sv
src/mips_core.sv
testbench/clk_gen.sv
testbench/mips_chk.sv
testbench/tb_mips.sv

/* Makefile */
TOP := tb_mips

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim +verilator+error+limit+100 | tee sim.log
	@grep -q -F -- '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
